// File: verilog.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/control_fsm.sv
verilog/instr_decode.sv
verilog/register_file.sv
verilog/alu.sv
verilog/unified_memory.sv
verilog/core_top.sv
bench/clock_gen.sv
bench/core_assertions.sv
bench/core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f verilog.f -o core_tb_sim

./obj_dir/core_tb_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
exit 0

// File: bench/core_tb.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module core_tb
  import rv_isa_pkg::*;
();

  localparam int    NUM_ENTRIES    = 14;
  localparam int    WORD_BITS      = $clog2(`MEM_WORDS);
  localparam int    RETIRE_TIMEOUT = 20;              // cycles
  localparam int    DATA_WORD      = 32'h100 >> 2;    // word used by sw and lw
  localparam data_t STORED_WORD    = 32'hEDCBAFFB;    // x2 ^ x1

  typedef struct packed {
    data_t      instr;
    data_t      pc;        // also the load address of instr
    logic [4:0] rd;
    logic       we;
    data_t      data;
    data_t      next_pc;
  } retire_t;

  logic                 clk;
  logic                 reset;
  logic                 load_en;
  logic [WORD_BITS-1:0] load_addr;
  data_t                load_data;
  logic                 retire_valid;
  data_t                retire_pc;
  logic [4:0]           retire_rd;
  logic                 retire_we;
  data_t                retire_data;

  retire_t prog [NUM_ENTRIES];

  clock_gen #(.LOAD_CYCLES(NUM_ENTRIES)) i_clock_gen
    ( .clk   ( clk   )
    , .reset ( reset )
    );

  core_top i_core_top
    ( .clk          ( clk          )
    , .reset        ( reset        )
    , .load_en      ( load_en      )
    , .load_addr    ( load_addr    )
    , .load_data    ( load_data    )
    , .retire_valid ( retire_valid )
    , .retire_pc    ( retire_pc    )
    , .retire_rd    ( retire_rd    )
    , .retire_we    ( retire_we    )
    , .retire_data  ( retire_data  )
    );

  bind core_top core_assertions i_core_assertions
    ( .clk          ( clk          )
    , .reset        ( reset        )
    , .pc_update    ( pc_update    )
    , .ir_write     ( ir_write     )
    , .reg_write    ( reg_write    )
    , .mem_write    ( mem_write    )
    , .retire_valid ( retire_valid )
    , .pc           ( pc           )
    );

  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic compare(input string what, input data_t got, input data_t expected);
    if (got !== expected) begin
      $display("Error: %s = %h, expected %h", what, got, expected);
      fail_run();
    end
  endtask

  task automatic set_entry(input int idx, input data_t instr, input data_t pc,
                           input logic [4:0] rd, input logic we, input data_t data,
                           input data_t next_pc);
    prog[idx] = '{instr: instr, pc: pc, rd: rd, we: we, data: data, next_pc: next_pc};
  endtask

  // ****************************************************************************
  // program and expected retire events
  // ****************************************************************************

  task automatic build_program();
    set_entry(0,  32'hFFB00093, 32'h00, 5'd1,  1'b1, 32'hFFFFFFFB, 32'h04);  // addi x1,x0,-5
    set_entry(1,  32'h12345137, 32'h04, 5'd2,  1'b1, 32'h12345000, 32'h08);  // lui x2,0x12345
    set_entry(2,  32'hFF00C193, 32'h08, 5'd3,  1'b1, 32'h0000000B, 32'h0C);  // xori x3,x1,-16
    set_entry(3,  32'hFFC0A213, 32'h0C, 5'd4,  1'b1, 32'h00000001, 32'h10);  // slti x4,x1,-4
    set_entry(4,  32'h401182B3, 32'h10, 5'd5,  1'b1, 32'h00000010, 32'h14);  // sub x5,x3,x1
    set_entry(5,  32'h00114333, 32'h14, 5'd6,  1'b1, STORED_WORD,  32'h18);  // xor x6,x2,x1
    set_entry(6,  32'h10602023, 32'h18, 5'd0,  1'b0, STORED_WORD,  32'h1C);  // sw x6,0x100(x0)
    set_entry(7,  32'h10002383, 32'h1C, 5'd7,  1'b1, STORED_WORD,  32'h20);  // lw x7,0x100(x0)
    set_entry(8,  32'h00638463, 32'h20, 5'd8,  1'b0, 32'h00000028, 32'h28);  // beq x7,x6,+8
    set_entry(9,  32'h00639463, 32'h28, 5'd8,  1'b0, 32'h00000030, 32'h2C);  // bne x7,x6,+8
    set_entry(10, 32'h00521663, 32'h2C, 5'd12, 1'b0, 32'h00000038, 32'h38);  // bne x4,x5,+12
    set_entry(11, 32'h0080046F, 32'h38, 5'd8,  1'b1, 32'h0000003C, 32'h40);  // jal x8,+8
    set_entry(12, 32'h00308663, 32'h40, 5'd12, 1'b0, 32'h0000004C, 32'h44);  // beq x1,x3,+12
    set_entry(13, 32'h00000063, 32'h44, 5'd0,  1'b0, 32'h00000044, 32'h44);  // beq x0,x0,0
  endtask

  task automatic load_program();
    @(posedge clk);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      #1;
      if (reset !== 1'b1) begin
        $display("reset was released before the program load finished");
        fail_run();
      end
      load_en   = 1'b1;
      load_addr = prog[i].pc[WORD_BITS+1:2];
      load_data = prog[i].instr;
      @(posedge clk);
    end
    #1 load_en = 1'b0;
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (reset !== 1'b0) begin
      if (cycles > NUM_ENTRIES + 10) begin
        $display("reset was never released");
        fail_run();
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  // outputs are sampled at the falling edge, mid cycle
  task automatic wait_retire();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (retire_valid !== 1'b1) begin
      cycles++;
      if (cycles > RETIRE_TIMEOUT) begin
        $display("no instruction retired within %0d cycles", RETIRE_TIMEOUT);
        fail_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic check_retire(input int idx);
    if (retire_we === 1'b1 && retire_rd == 5'd0) begin
      $display("register x0 reported as written with %h", retire_data);
      fail_run();
    end
    compare("retire_pc", retire_pc, prog[idx].pc);
    compare("retire_rd", {27'b0, retire_rd}, {27'b0, prog[idx].rd});
    compare("retire_we", {31'b0, retire_we}, {31'b0, prog[idx].we});
    compare("retire_data", retire_data, prog[idx].data);
  endtask

  // ****************************************************************************
  // main sequence
  // ****************************************************************************

  initial begin
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    build_program();
    load_program();
    wait_reset_release();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      wait_retire();
      check_retire(i);
      if (i > 0) begin
        compare("retire_pc", retire_pc, prog[i-1].next_pc);   // branch or jump target
      end
    end
    wait_retire();                                             // last beq spins in place
    compare("retire_pc", retire_pc, prog[NUM_ENTRIES-1].next_pc);
    compare("mem[DATA_WORD]", i_core_top.i_unified_memory.mem[DATA_WORD], STORED_WORD);
    compare("mem[0]", i_core_top.i_unified_memory.mem[0], prog[0].instr);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: bench/core_assertions.sv
`timescale 1ns/1ps

module core_assertions
  import rv_isa_pkg::*;
( input logic  clk
, input logic  reset
, input logic  pc_update
, input logic  ir_write
, input logic  reg_write
, input logic  mem_write
, input logic  retire_valid
, input data_t pc
);

  // ****************************************************************************
  // retire pulse and enable rules
  // ****************************************************************************

  retire_single: assert property (
    @(posedge clk) disable iff (reset) retire_valid |=> !retire_valid
  ) else $error("retire_valid high on two consecutive cycles");

  fetch_not_writeback: assert property (
    @(posedge clk) !(ir_write && reg_write)
  ) else $error("ir_write and reg_write high in the same cycle");

  pc_aligned: assert property (
    @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
  ) else $error("pc %h is not word aligned", pc);

  quiet_in_reset: assert property (
    @(posedge clk) reset |-> !(pc_update || ir_write || reg_write || mem_write || retire_valid)
  ) else $error("an enable is active while reset is high");

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
  parameter int LOAD_CYCLES = 0   // extra reset cycles that cover the program load
)
( output logic clk
, output logic reset
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;       // 40 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (LOAD_CYCLES + 5) @(posedge clk);
    #1 reset = 1'b0;              // released just after an edge, like other stimulus
  end

endmodule

// File: verilog/core_top.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module core_top
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
( input  logic                         clk
, input  logic                         reset
, input  logic                         load_en
, input  logic [$clog2(`MEM_WORDS)-1:0] load_addr
, input  data_t                        load_data
, output logic                         retire_valid
, output data_t                        retire_pc
, output logic [4:0]                   retire_rd
, output logic                         retire_we
, output data_t                        retire_data
);

  logic        pc_update, ir_write, reg_write, mem_write;
  adr_src_t    adr_src;
  alu_src_a_t  alu_src_a;
  alu_src_b_t  alu_src_b;
  result_src_t result_src;

  data_t       pc, old_pc, instr, data_q, alu_out, rd1_q, rd2_q;
  data_t       mem_addr, mem_rd, rd1, rd2, imm_ext;
  data_t       src_a, src_b, alu_result, result;
  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [4:0]  rd, rs1, rs2;
  alu_op_t     dec_alu_op, alu_op;
  logic        zero;

  // ****************************************************************************
  // state registers
  // ****************************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (pc_update) begin
      pc <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (ir_write) begin
      instr  <= mem_rd;
      old_pc <= pc;        // pc of the instruction being fetched
    end
    data_q  <= mem_rd;
    alu_out <= alu_result;
    rd1_q   <= rd1;
    rd2_q   <= rd2;
  end

  // ****************************************************************************
  // multiplexers
  // ****************************************************************************

  assign mem_addr = (adr_src == ADR_RESULT) ? result : pc;

  always_comb begin
    case (alu_src_a)
      SRC_A_OLD_PC: src_a = old_pc;
      SRC_A_RD1:    src_a = rd1_q;
      SRC_A_ZERO:   src_a = '0;
      default:      src_a = pc;
    endcase
  end

  always_comb begin
    case (alu_src_b)
      SRC_B_RD2: src_b = rd2_q;
      SRC_B_IMM: src_b = imm_ext;
      default:   src_b = 32'd4;
    endcase
  end

  always_comb begin
    case (result_src)
      RES_DATA:       result = data_q;
      RES_ALU_RESULT: result = alu_result;
      default:        result = alu_out;
    endcase
  end

  // decoded op only applies when rs1 is an operand, else address arithmetic
  assign alu_op = (alu_src_a == SRC_A_RD1) ? dec_alu_op : ALU_ADD;

  // retire port, stored word reported for sw
  assign retire_pc   = old_pc;
  assign retire_rd   = rd;
  assign retire_we   = reg_write && (rd != 5'd0);
  assign retire_data = mem_write ? rd2_q : result;

  // ****************************************************************************
  // instances
  // ****************************************************************************

  control_fsm i_control_fsm
    ( .clk          ( clk          )
    , .reset        ( reset        )
    , .opcode       ( opcode       )
    , .funct3       ( funct3       )
    , .zero         ( zero         )
    , .pc_update    ( pc_update    )
    , .ir_write     ( ir_write     )
    , .reg_write    ( reg_write    )
    , .mem_write    ( mem_write    )
    , .retire_valid ( retire_valid )
    , .adr_src      ( adr_src      )
    , .alu_src_a    ( alu_src_a    )
    , .alu_src_b    ( alu_src_b    )
    , .result_src   ( result_src   )
    );

  instr_decode i_instr_decode
    ( .instr   ( instr      )
    , .opcode  ( opcode     )
    , .funct3  ( funct3     )
    , .rd      ( rd         )
    , .rs1     ( rs1        )
    , .rs2     ( rs2        )
    , .imm_ext ( imm_ext    )
    , .alu_op  ( dec_alu_op )
    );

  register_file i_register_file
    ( .clk   ( clk       )
    , .reset ( reset     )
    , .rs1   ( rs1       )
    , .rs2   ( rs2       )
    , .rd    ( rd        )
    , .we    ( reg_write )
    , .wd    ( result    )
    , .rd1   ( rd1       )
    , .rd2   ( rd2       )
    );

  alu i_alu
    ( .a    ( src_a      )
    , .b    ( src_b      )
    , .op   ( alu_op     )
    , .y    ( alu_result )
    , .zero ( zero       )
    );

  unified_memory i_unified_memory
    ( .clk       ( clk                 )
    , .addr      ( mem_addr            )
    , .wd        ( rd2_q               )
    , .we        ( mem_write && !reset )
    , .load_en   ( load_en && reset    )   // program load only under reset
    , .load_addr ( load_addr           )
    , .load_data ( load_data           )
    , .rd        ( mem_rd              )
    );

endmodule

// File: verilog/unified_memory.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module unified_memory
  import rv_isa_pkg::*;
( input  logic                         clk
, input  data_t                        addr
, input  data_t                        wd
, input  logic                         we
, input  logic                         load_en
, input  logic [$clog2(`MEM_WORDS)-1:0] load_addr
, input  data_t                        load_data
, output data_t                        rd
);

  localparam int WORD_BITS = $clog2(`MEM_WORDS);

  data_t                mem [`MEM_WORDS];
  logic [WORD_BITS-1:0] word_idx;

  assign word_idx = addr[WORD_BITS+1:2];   // byte address to word index
  assign rd       = mem[word_idx];

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;         // program load wins
    end else if (we) begin
      mem[word_idx] <= wd;
    end
  end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu
  import rv_isa_pkg::*;
( input  data_t   a
, input  data_t   b
, input  alu_op_t op
, output data_t   y
, output logic    zero
);

  logic lt;

  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      ALU_ADD: y = a + b;
      ALU_SUB: y = a - b;
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_XOR: y = a ^ b;
      ALU_SLT: y = {{($bits(data_t)-1){1'b0}}, lt};
      default: y = a + b;
    endcase
  end

  assign zero = (y == '0);   // equality test for branches

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module register_file
  import rv_isa_pkg::*;
( input  logic       clk
, input  logic       reset
, input  logic [4:0] rs1
, input  logic [4:0] rs2
, input  logic [4:0] rd
, input  logic       we
, input  data_t      wd
, output data_t      rd1
, output data_t      rd2
);

  data_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wd;
    end
  end

  assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: verilog/instr_decode.sv
`timescale 1ns/1ps

module instr_decode
  import rv_isa_pkg::*;
( input  data_t      instr
, output opcode_t    opcode
, output logic [2:0] funct3
, output logic [4:0] rd
, output logic [4:0] rs1
, output logic [4:0] rs2
, output data_t      imm_ext
, output alu_op_t    alu_op
);

  assign opcode = opcode_t'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  always_comb begin
    case (opcode)
      OP_STORE:  imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      OP_BRANCH: imm_ext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
      OP_JAL:    imm_ext = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
      OP_LUI:    imm_ext = {instr[31:12], 12'b0};
      default:   imm_ext = {{20{instr[31]}}, instr[31:20]};   // I format
    endcase
  end

  always_comb begin
    alu_op = ALU_ADD;
    if (opcode == OP_R || opcode == OP_I) begin
      case (funct3)
        // only R type has sub, selected by funct7 bit 5
        F3_ADD:  alu_op = (opcode == OP_R && instr[30]) ? ALU_SUB : ALU_ADD;
        F3_SLT:  alu_op = ALU_SLT;
        F3_XOR:  alu_op = ALU_XOR;
        F3_OR:   alu_op = ALU_OR;
        F3_AND:  alu_op = ALU_AND;
        default: alu_op = ALU_ADD;
      endcase
    end else if (opcode == OP_BRANCH) begin
      alu_op = ALU_SUB;
    end
  end

endmodule

// File: verilog/control_fsm.sv
`timescale 1ns/1ps

module control_fsm
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
( input  logic        clk
, input  logic        reset
, input  opcode_t     opcode
, input  logic [2:0]  funct3
, input  logic        zero
, output logic        pc_update
, output logic        ir_write
, output logic        reg_write
, output logic        mem_write
, output logic        retire_valid
, output adr_src_t    adr_src
, output alu_src_a_t  alu_src_a
, output alu_src_b_t  alu_src_b
, output result_src_t result_src
);

  fsm_state_t state;
  fsm_state_t state_next;
  logic       active;       // low for the first cycle out of reset
  logic       take_branch;

  assign take_branch = zero ^ funct3[0];  // beq on equal, bne on not equal

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= FETCH;
      active <= 1'b0;
    end else begin
      state  <= state_next;
      active <= 1'b1;
    end
  end

  // ****************************************************************************
  // next state
  // ****************************************************************************

  always_comb begin
    state_next = FETCH;
    case (state)
      FETCH:    state_next = active ? DECODE : FETCH;
      DECODE: begin
        case (opcode)
          OP_R:               state_next = EXEC_R;
          OP_I:               state_next = EXEC_I;
          OP_LOAD, OP_STORE:  state_next = MEM_ADDR;
          OP_BRANCH:          state_next = BRANCH;
          OP_JAL:             state_next = JAL;
          OP_LUI:             state_next = LUI;
          default:            state_next = FETCH;   // unsupported, dropped
        endcase
      end
      EXEC_R, EXEC_I, JAL, LUI: state_next = WB_ALU;
      MEM_ADDR: state_next = (opcode == OP_LOAD) ? MEM_READ : MEM_WRITE;
      MEM_READ: state_next = WB_MEM;
      default:  state_next = FETCH;                 // final states
    endcase
  end

  // ****************************************************************************
  // enables and selects
  // ****************************************************************************

  always_comb begin
    pc_update    = 1'b0;
    ir_write     = 1'b0;
    reg_write    = 1'b0;
    mem_write    = 1'b0;
    retire_valid = 1'b0;
    adr_src      = ADR_PC;
    alu_src_a    = SRC_A_PC;
    alu_src_b    = SRC_B_FOUR;
    result_src   = RES_ALU_RESULT;
    case (state)
      FETCH: begin
        ir_write  = active;
        pc_update = active;                 // pc <= pc + 4
      end
      DECODE: begin
        alu_src_a = SRC_A_OLD_PC;           // branch/jump target into alu_out
        alu_src_b = SRC_B_IMM;
      end
      EXEC_R: begin
        alu_src_a = SRC_A_RD1;
        alu_src_b = SRC_B_RD2;
      end
      EXEC_I, MEM_ADDR: begin
        alu_src_a = SRC_A_RD1;
        alu_src_b = SRC_B_IMM;
      end
      MEM_READ: begin
        adr_src    = ADR_RESULT;
        result_src = RES_ALU_OUT;
      end
      MEM_WRITE: begin
        adr_src      = ADR_RESULT;
        result_src   = RES_ALU_OUT;
        mem_write    = 1'b1;
        retire_valid = 1'b1;
      end
      WB_ALU: begin
        result_src   = RES_ALU_OUT;
        reg_write    = 1'b1;
        retire_valid = 1'b1;
      end
      WB_MEM: begin
        result_src   = RES_DATA;
        reg_write    = 1'b1;
        retire_valid = 1'b1;
      end
      BRANCH: begin
        alu_src_a    = SRC_A_RD1;           // rs1 - rs2 sets zero
        alu_src_b    = SRC_B_RD2;
        result_src   = RES_ALU_OUT;
        pc_update    = take_branch;
        retire_valid = 1'b1;
      end
      JAL: begin
        alu_src_a  = SRC_A_OLD_PC;          // link value for WB_ALU
        result_src = RES_ALU_OUT;
        pc_update  = 1'b1;
      end
      LUI: begin
        alu_src_a = SRC_A_ZERO;
        alu_src_b = SRC_B_IMM;
      end
      default: ;
    endcase
  end

endmodule

// File: verilog/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  typedef enum logic [3:0] {
    FETCH     = 4'd0,
    DECODE    = 4'd1,
    EXEC_R    = 4'd2,
    EXEC_I    = 4'd3,
    MEM_ADDR  = 4'd4,
    MEM_READ  = 4'd5,
    MEM_WRITE = 4'd6,
    WB_ALU    = 4'd7,
    WB_MEM    = 4'd8,
    BRANCH    = 4'd9,
    JAL       = 4'd10,
    LUI       = 4'd11
  } fsm_state_t;

  typedef enum logic [1:0] {ADR_PC, ADR_RESULT} adr_src_t;

  typedef enum logic [1:0] {SRC_A_PC, SRC_A_OLD_PC, SRC_A_RD1, SRC_A_ZERO} alu_src_a_t;

  typedef enum logic [1:0] {SRC_B_RD2, SRC_B_IMM, SRC_B_FOUR} alu_src_b_t;

  // the PC always reloads from the result bus
  typedef enum logic [1:0] {
    RES_ALU_OUT,
    RES_DATA,
    RES_ALU_RESULT
  } result_src_t;

endpackage

// File: verilog/rv_isa_pkg.sv
`include "rv_consts.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] data_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,
    OP_I      = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_LUI    = 7'b0110111
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5   // signed compare
  } alu_op_t;

  // funct3 codes shared by R and I types
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

endpackage

// File: verilog/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ****************************************************************************
// core sizing
// ****************************************************************************

`define XLEN 32         // data and address width

`define MEM_WORDS 256   // unified memory depth, byte address bits 9:2

`define NUM_REGS 32     // architectural integer registers

`endif
